/* Bender.yml */
package:
  name: asym_buf

sources:
  - asym_buf_pkg.sv
  - t2p_ram.sv
  - asym_ram.sv
  - wb_write_port.sv
  - wb_read_port.sv
  - asym_buf_top.sv
  - target: simulation
    files:
      - asym_buf_asserts.sv
      - asym_buf_tb.sv

/* asym_buf_asserts.sv */
`timescale 1ns/1ns

module asym_buf_asserts (
   input logic                      r_clk,
   input logic                      reset,
   input asym_buf_pkg::wb_wr_req_t  wr_req,
   input asym_buf_pkg::wb_wr_rsp_t  wr_rsp,
   input asym_buf_pkg::wb_rd_req_t  rd_req,
   input asym_buf_pkg::wb_rd_rsp_t  rd_rsp
);

   int fail_cnt;

   initial fail_cnt = 0;

   // ack only while the master still holds stb
   wr_ack_with_stb: assert property (@(posedge r_clk) disable iff (reset)
      wr_rsp.ack |-> wr_req.stb)
      else begin
         fail_cnt++;
         $error("write ack without stb");
      end

   rd_ack_with_stb: assert property (@(posedge r_clk) disable iff (reset)
      rd_rsp.ack |-> rd_req.stb)
      else begin
         fail_cnt++;
         $error("read ack without stb");
      end

   // single-cycle ack
   wr_ack_pulse: assert property (@(posedge r_clk) disable iff (reset)
      wr_rsp.ack |=> !wr_rsp.ack)
      else begin
         fail_cnt++;
         $error("write ack held for two cycles");
      end

   rd_ack_pulse: assert property (@(posedge r_clk) disable iff (reset)
      rd_rsp.ack |=> !rd_rsp.ack)
      else begin
         fail_cnt++;
         $error("read ack held for two cycles");
      end

   no_ack_in_reset: assert property (@(posedge r_clk)
      reset |=> !wr_rsp.ack && !rd_rsp.ack)
      else begin
         fail_cnt++;
         $error("ack raised while in reset");
      end

   // latency counted from the rising stb of a new request
   wr_ack_latency: assert property (@(posedge r_clk) disable iff (reset)
      $rose(wr_req.stb) && wr_req.cyc && wr_req.we |=> wr_rsp.ack)
      else begin
         fail_cnt++;
         $error("write ack not one cycle after stb");
      end

   rd_ack_latency: assert property (@(posedge r_clk) disable iff (reset)
      $rose(rd_req.stb) && rd_req.cyc && !rd_req.we |=> !rd_rsp.ack ##1 rd_rsp.ack)
      else begin
         fail_cnt++;
         $error("read ack not two cycles after stb");
      end

endmodule

bind asym_buf_top asym_buf_asserts asym_buf_asserts_i (
   .r_clk  (r_clk),
   .reset  (reset),
   .wr_req (wr_req),
   .wr_rsp (wr_rsp),
   .rd_req (rd_req),
   .rd_rsp (rd_rsp)
);

/* asym_buf_pkg.sv */
package asym_buf_pkg;

   // write side, one wide word per address
   localparam int W_DATA_W = 32;
   localparam int W_ADDR_W = 6;

   // read side, one byte per address
   localparam int R_DATA_W = 8;
   localparam int R_ADDR_W = 8;

   // width ratio and the lane select that goes with it
   localparam int LANES  = W_DATA_W / R_DATA_W;
   localparam int LANE_W = R_ADDR_W - W_ADDR_W;

   typedef logic [W_DATA_W-1:0] wide_word_t;
   typedef logic [R_DATA_W-1:0] slice_t;

   // write port, Wishbone classic, no byte selects
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [W_ADDR_W-1:0] adr;
      wide_word_t          dat;
   } wb_wr_req_t;

   typedef struct packed {
      logic ack;
   } wb_wr_rsp_t;

   // read port, byte addressed
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [R_ADDR_W-1:0] adr;
   } wb_rd_req_t;

   typedef struct packed {
      logic   ack;
      slice_t dat;
   } wb_rd_rsp_t;

endpackage

/* asym_buf_tb.sv */
`timescale 1ns/1ns

module asym_buf_tb;

   localparam int          N_DIRECTED  = 21;
   localparam int          N_ROWS      = 64;
   localparam int          CYCLE_LIMIT = 40 * N_ROWS + 100;
   localparam logic [15:0] LFSR_SEED   = 16'd55659;
   localparam logic [15:0] LFSR_TAPS   = 16'hB400;

   // one transaction; addr is a word address for writes, a byte address for reads
   typedef struct packed {
      logic        is_wr;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [7:0]  exp;
   } row_t;

   logic                      r_clk;
   logic                      reset;
   asym_buf_pkg::wb_wr_req_t  wr_req;
   asym_buf_pkg::wb_wr_rsp_t  wr_rsp;
   asym_buf_pkg::wb_rd_req_t  rd_req;
   asym_buf_pkg::wb_rd_rsp_t  rd_rsp;

   row_t        rows [N_ROWS];
   logic [7:0]  ref_mem [256];
   logic [63:0] word_written;
   logic [15:0] lfsr_q;
   int          errors;
   int          checks;
   int          assert_fails;
   int          cycle_cnt;

   asym_buf_top asym_buf_top_i (
      .r_clk  (r_clk),
      .reset  (reset),
      .wr_req (wr_req),
      .wr_rsp (wr_rsp),
      .rd_req (rd_req),
      .rd_rsp (rd_rsp)
   );

   initial begin
      r_clk = 1'b0;
      forever #20 r_clk = ~r_clk;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic lsb;
      lsb = s[0];
      s   = s >> 1;
      if (lsb) begin
         s = s ^ LFSR_TAPS;
      end
      return s;
   endfunction

   // one LFSR step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
      return v;
   endfunction

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic set_row(input int idx, input logic is_wr, input logic [7:0] addr,
                          input logic [31:0] data, input logic [7:0] exp);
      rows[idx].is_wr = is_wr;
      rows[idx].addr  = addr;
      rows[idx].data  = data;
      rows[idx].exp   = exp;
   endtask

   task automatic load_directed();
      // lane order after a single write
      set_row(0,  1'b1, 8'd0,   32'h0F1E2D3C, 8'h00);
      set_row(1,  1'b1, 8'd1,   32'h44332211, 8'h00);
      set_row(2,  1'b0, 8'd4,   32'h0,        8'h11);
      set_row(3,  1'b0, 8'd5,   32'h0,        8'h22);
      set_row(4,  1'b0, 8'd6,   32'h0,        8'h33);
      set_row(5,  1'b0, 8'd7,   32'h0,        8'h44);
      // overwrite word 1 between two neighbours
      set_row(6,  1'b1, 8'd2,   32'h8C7B6A59, 8'h00);
      set_row(7,  1'b1, 8'd63,  32'hF0E1D2C3, 8'h00);
      set_row(8,  1'b1, 8'd1,   32'hDDCCBBAA, 8'h00);
      set_row(9,  1'b0, 8'd4,   32'h0,        8'hAA);
      set_row(10, 1'b0, 8'd5,   32'h0,        8'hBB);
      set_row(11, 1'b0, 8'd6,   32'h0,        8'hCC);
      set_row(12, 1'b0, 8'd7,   32'h0,        8'hDD);
      set_row(13, 1'b0, 8'd8,   32'h0,        8'h59);
      set_row(14, 1'b0, 8'd11,  32'h0,        8'h8C);
      set_row(15, 1'b0, 8'd1,   32'h0,        8'h2D);
      // first and last word
      set_row(16, 1'b0, 8'd0,   32'h0,        8'h3C);
      set_row(17, 1'b0, 8'd3,   32'h0,        8'h0F);
      set_row(18, 1'b0, 8'd252, 32'h0,        8'hC3);
      set_row(19, 1'b0, 8'd253, 32'h0,        8'hD2);
      set_row(20, 1'b0, 8'd255, 32'h0,        8'hF0);
   endtask

   // random rows on words 0..15, expected bytes taken from the model
   task automatic fill_random();
      logic       op;
      logic [3:0] word;
      logic [1:0] lane;
      word_written = '0;
      for (int i = 0; i < N_ROWS; i++) begin
         if (i >= N_DIRECTED) begin
            op   = take_bits(1);
            word = take_bits(4);
            lane = take_bits(2);
            rows[i].data = take_bits(32);
            // nothing to read back yet
            if (!op && !word_written[word]) begin
               op = 1'b1;
            end
            rows[i].is_wr = op;
            rows[i].addr  = op ? {4'b0, word} : {2'b0, word, lane};
            rows[i].exp   = 8'h00;
         end
         if (rows[i].is_wr) begin
            for (int l = 0; l < 4; l++) begin
               ref_mem[{rows[i].addr[5:0], l[1:0]}] = rows[i].data[8*l +: 8];
            end
            word_written[rows[i].addr[5:0]] = 1'b1;
         end else if (i >= N_DIRECTED) begin
            rows[i].exp = ref_mem[rows[i].addr];
         end
      end
   endtask

   task automatic apply_row(input int idx);
      row_t  row;
      int    waited;
      string tag;
      row    = rows[idx];
      waited = 0;
      tag    = $sformatf("row %0d", idx);
      if (row.is_wr) begin
         wr_req.cyc = 1'b1;
         wr_req.stb = 1'b1;
         wr_req.we  = 1'b1;
         wr_req.adr = row.addr[asym_buf_pkg::W_ADDR_W-1:0];
         wr_req.dat = row.data;
         do begin
            @(negedge r_clk);
            waited++;
         end while (wr_rsp.ack !== 1'b1);
         compare(waited, 1, {tag, " write ack latency"});
         // stb stays up through the ack cycle
         @(negedge r_clk);
         wr_req = '0;
      end else begin
         rd_req.cyc = 1'b1;
         rd_req.stb = 1'b1;
         rd_req.we  = 1'b0;
         rd_req.adr = row.addr;
         do begin
            @(negedge r_clk);
            waited++;
         end while (rd_rsp.ack !== 1'b1);
         compare(waited, 2, {tag, " read ack latency"});
         compare(rd_rsp.dat, row.exp, {tag, " read data"});
         @(negedge r_clk);
         rd_req = '0;
      end
      @(negedge r_clk);
   endtask

   initial begin
      reset     = 1'b1;
      wr_req    = '0;
      rd_req    = '0;
      errors    = 0;
      checks    = 0;
      lfsr_q    = LFSR_SEED;
      load_directed();
      fill_random();

      repeat (2) begin
         @(posedge r_clk);
         @(negedge r_clk);
         compare(wr_rsp.ack, 0, "write ack in reset");
         compare(rd_rsp.ack, 0, "read ack in reset");
      end
      reset = 1'b0;
      repeat (2) begin
         @(negedge r_clk);
         compare(wr_rsp.ack, 0, "write ack after reset");
         compare(rd_rsp.ack, 0, "read ack after reset");
      end

      for (int i = 0; i < N_ROWS; i++) begin
         apply_row(i);
      end

      assert_fails = asym_buf_top_i.asym_buf_asserts_i.fail_cnt;
      $display("%0d checks, %0d mismatches, %0d assertion failures",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // watchdog, generous per-row budget
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge r_clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
   end

endmodule

/* asym_buf_top.sv */
`timescale 1ns/1ns

module asym_buf_top (
   input  logic                      r_clk,
   input  logic                      reset,

   // producer side, 32-bit words
   input  asym_buf_pkg::wb_wr_req_t  wr_req,
   output asym_buf_pkg::wb_wr_rsp_t  wr_rsp,

   // consumer side, single bytes
   input  asym_buf_pkg::wb_rd_req_t  rd_req,
   output asym_buf_pkg::wb_rd_rsp_t  rd_rsp
);

   logic                               wr_en;
   logic [asym_buf_pkg::W_ADDR_W-1:0]  wr_addr;
   asym_buf_pkg::wide_word_t           wr_data;

   logic                               rd_en;
   logic [asym_buf_pkg::R_ADDR_W-1:0]  rd_addr;
   asym_buf_pkg::slice_t               rd_data;

   wb_write_port wb_write_port_i (
      .r_clk   (r_clk),
      .reset   (reset),
      .req     (wr_req),
      .rsp     (wr_rsp),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data)
   );

   wb_read_port wb_read_port_i (
      .r_clk   (r_clk),
      .reset   (reset),
      .req     (rd_req),
      .rsp     (rd_rsp),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   asym_ram asym_ram_i (
      .r_clk   (r_clk),
      .reset   (reset),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

/* asym_ram.sv */
`timescale 1ns/1ns

module asym_ram (
   input  logic                               r_clk,
   input  logic                               reset,

   // wide write side
   input  logic                               wr_en,
   input  logic [asym_buf_pkg::W_ADDR_W-1:0]  wr_addr,
   input  asym_buf_pkg::wide_word_t           wr_data,

   // narrow read side
   input  logic                               rd_en,
   input  logic [asym_buf_pkg::R_ADDR_W-1:0]  rd_addr,
   output asym_buf_pkg::slice_t               rd_data
);

   localparam int LANES    = asym_buf_pkg::LANES;
   localparam int LANE_W   = asym_buf_pkg::LANE_W;
   localparam int R_DATA_W = asym_buf_pkg::R_DATA_W;
   localparam int R_ADDR_W = asym_buf_pkg::R_ADDR_W;
   localparam int W_ADDR_W = asym_buf_pkg::W_ADDR_W;

   // word address shared by every bank on the read side
   logic [W_ADDR_W-1:0]   rd_word_addr;
   logic [LANE_W-1:0]     lane_q;
   asym_buf_pkg::slice_t  bank_rd [LANES];

   assign rd_word_addr = rd_addr[R_ADDR_W-1 -: W_ADDR_W];

   // all banks written together, one lane each
   for (genvar i = 0; i < LANES; i++) begin : g_bank
      t2p_ram bank_i (
         .r_clk  (r_clk),
         .w_en   (wr_en),
         .w_addr (wr_addr),
         .w_data (wr_data[i*R_DATA_W +: R_DATA_W]),
         .r_en   (rd_en),
         .r_addr (rd_word_addr),
         .r_data (bank_rd[i])
      );
   end

   // lane select follows the bank read by one cycle
   always_ff @(posedge r_clk) begin
      if (reset) begin
         lane_q <= '0;
      end else if (rd_en) begin
         lane_q <= rd_addr[LANE_W-1:0];
      end
   end

   assign rd_data = bank_rd[lane_q];

endmodule

/* project.f */
asym_buf_pkg.sv
t2p_ram.sv
asym_ram.sv
wb_write_port.sv
wb_read_port.sv
asym_buf_top.sv
asym_buf_asserts.sv
asym_buf_tb.sv

/* t2p_ram.sv */
`timescale 1ns/1ns

module t2p_ram (
   input  logic                               r_clk,

   input  logic                               w_en,
   input  logic [asym_buf_pkg::W_ADDR_W-1:0]  w_addr,
   input  asym_buf_pkg::slice_t               w_data,

   input  logic                               r_en,
   input  logic [asym_buf_pkg::W_ADDR_W-1:0]  r_addr,
   output asym_buf_pkg::slice_t               r_data
);

   localparam int DEPTH = 2 ** asym_buf_pkg::W_ADDR_W;

   asym_buf_pkg::slice_t mem [DEPTH];

   // write side
   always_ff @(posedge r_clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // registered read, output holds between reads
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

/* wb_read_port.sv */
`timescale 1ns/1ns

module wb_read_port (
   input  logic                               r_clk,
   input  logic                               reset,

   input  asym_buf_pkg::wb_rd_req_t           req,
   output asym_buf_pkg::wb_rd_rsp_t           rsp,

   output logic                               rd_en,
   output logic [asym_buf_pkg::R_ADDR_W-1:0]  rd_addr,
   input  asym_buf_pkg::slice_t               rd_data
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_DATA,
      ST_ACK
   } state_t;

   state_t               state_q;
   state_t               state_d;
   logic                 ack_q;
   asym_buf_pkg::slice_t dat_q;

   // accept only in idle, write requests on this port are never acked
   assign rd_en   = (state_q == ST_IDLE) & req.cyc & req.stb & ~req.we;
   assign rd_addr = req.adr;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (rd_en) begin
               state_d = ST_WAIT_DATA;
            end
         end
         ST_WAIT_DATA: begin
            state_d = ST_ACK;
         end
         // stb still high here, master drops it next cycle
         ST_ACK: begin
            state_d = ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge r_clk) begin
      if (reset) begin
         state_q <= ST_IDLE;
         ack_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         ack_q   <= (state_q == ST_WAIT_DATA);
      end
   end

   // RAM output is valid in the wait cycle
   always_ff @(posedge r_clk) begin
      if (state_q == ST_WAIT_DATA) begin
         dat_q <= rd_data;
      end
   end

   assign rsp.ack = ack_q;
   assign rsp.dat = dat_q;

endmodule

/* wb_write_port.sv */
`timescale 1ns/1ns

module wb_write_port (
   input  logic                               r_clk,
   input  logic                               reset,

   input  asym_buf_pkg::wb_wr_req_t           req,
   output asym_buf_pkg::wb_wr_rsp_t           rsp,

   output logic                               wr_en,
   output logic [asym_buf_pkg::W_ADDR_W-1:0]  wr_addr,
   output asym_buf_pkg::wide_word_t           wr_data
);

   logic ack_q;

   // a write cycle not yet acked; ack blocks the repeat while stb is still up
   assign wr_en   = req.cyc & req.stb & req.we & ~ack_q;
   assign wr_addr = req.adr;
   assign wr_data = req.dat;

   // ack one cycle after the RAM write
   always_ff @(posedge r_clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wr_en;
      end
   end

   assign rsp.ack = ack_q;

endmodule
